//--- rtl/tcp_settings.svh
`ifndef TCP_SETTINGS_SVH
`define TCP_SETTINGS_SVH

// Cycles from the first unacknowledged segment to a forced ACK request
`define TCP_ACK_TIMEOUT 20

// Accepted payload segments that request an ACK at once
`define TCP_FORCE_ACK_PACKETS 4

`endif

//--- rtl/tcp_pkg.sv
package tcp_pkg;

  // TCP flag byte, MSB first as on the wire
  typedef struct packed {
    logic cwr;
    logic ece;
    logic urg;
    logic ack;
    logic psh;
    logic rst;
    logic syn;
    logic fin;
  } tcp_flags_t;

  // 20-byte fixed header, src_port in the top bits
  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq_num;
    logic [31:0] ack_num;
    logic [3:0]  data_off; // Header length in 32-bit words
    logic [3:0]  rsvd;
    tcp_flags_t  flags;
    logic [15:0] win;
    logic [15:0] chksum;
    logic [15:0] urg_ptr;
  } tcp_hdr_t;

  typedef struct packed {
    logic        val;
    logic        sof;
    logic        eof;
    logic        err;
    logic [7:0]  dat;
    logic [15:0] seg_len; // Valid on sof
  } tcp_strm_t;

  typedef struct packed {
    logic       val;
    logic       err;
    logic       eof;
    logic [7:0] dat;
  } tcp_data_t;

  typedef struct packed {
    logic        val;     // One-cycle pulse per parsed header
    tcp_hdr_t    hdr;
    logic [15:0] pld_len;
  } tcp_meta_t;

  // Connection block
  typedef struct packed {
    logic [15:0] loc_port;
    logic [15:0] rem_port;
    logic [31:0] rem_seq;  // Starting local ACK number
  } tcp_tcb_t;

  typedef enum logic {
    tcp_closed,
    tcp_connected
  } tcp_status_t;

endpackage

//--- rtl/tcp_rx_hdr_parse.sv
`timescale 1ns/1ns

module tcp_rx_hdr_parse (
  input  logic               clk,
  input  logic               rst,
  input  tcp_pkg::tcp_strm_t rx,
  output tcp_pkg::tcp_meta_t meta,
  output tcp_pkg::tcp_strm_t pld
);

  logic             in_hdr;    // Taking header or option bytes
  logic             in_pld;    // Taking payload bytes
  logic             first_pld; // Next payload byte is the first one
  logic [5:0]       byte_cnt;  // Index of the current header byte
  logic [159:0]     hdr_q;
  logic [159:0]     hdr_nxt;
  logic [3:0]       off_q;
  logic [5:0]       hlen;
  logic [15:0]      seg_len_q;
  logic [15:0]      pld_len_nxt;
  logic             hdr_last;

  logic             meta_val;
  tcp_pkg::tcp_hdr_t meta_hdr;
  logic [15:0]      meta_len;

  logic             pld_val;
  logic             pld_sof;
  logic             pld_eof;
  logic             pld_err;
  logic [7:0]       pld_dat;

  // Header bytes shift in MSB first, options leave the register alone
  assign hdr_nxt = (rx.sof || byte_cnt < 6'd20) ? {hdr_q[151:0], rx.dat} : hdr_q;

  // data_off below 5 is malformed, treat it as a bare header
  assign hlen = (off_q < 4'd5) ? 6'd20 : {off_q, 2'b00};

  assign hdr_last = rx.val && !rx.sof && in_hdr &&
                    (byte_cnt >= 6'd19) && (byte_cnt == hlen - 6'd1);

  assign pld_len_nxt = (seg_len_q > {10'd0, hlen}) ? seg_len_q - {10'd0, hlen} : 16'd0;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_hdr    <= 1'b0;
      in_pld    <= 1'b0;
      first_pld <= 1'b0;
      meta_val  <= 1'b0;
      pld_val   <= 1'b0;
    end else begin
      meta_val <= 1'b0;
      pld_val  <= rx.val && in_pld && !rx.sof;
      if (rx.val) begin
        if (rx.sof) begin
          // New segment restarts the parse, even mid-segment
          in_hdr <= !rx.eof;
          in_pld <= 1'b0;
        end else if (in_hdr) begin
          if (hdr_last) begin
            in_hdr    <= 1'b0;
            in_pld    <= !rx.eof;
            first_pld <= 1'b1;
            meta_val  <= 1'b1;
          end else if (rx.eof) begin
            in_hdr <= 1'b0; // Truncated header, drop
          end
        end else if (in_pld) begin
          first_pld <= 1'b0;
          if (rx.eof) begin
            in_pld <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx.val && (rx.sof || in_hdr)) begin
      hdr_q    <= hdr_nxt;
      byte_cnt <= rx.sof ? 6'd1 : byte_cnt + 6'd1;
    end
    if (rx.val && rx.sof) begin
      seg_len_q <= rx.seg_len;
    end
    // Byte 12 carries data_off in its upper nibble
    if (rx.val && !rx.sof && in_hdr && byte_cnt == 6'd12) begin
      off_q <= rx.dat[7:4];
    end
    if (hdr_last) begin
      meta_hdr <= hdr_nxt;
      meta_len <= pld_len_nxt;
    end
    pld_dat <= rx.dat;
    pld_eof <= rx.eof;
    pld_err <= rx.err;
    pld_sof <= first_pld;
  end

  assign meta = '{val: meta_val, hdr: meta_hdr, pld_len: meta_len};

  assign pld = '{
    val:     pld_val,
    sof:     pld_sof,
    eof:     pld_eof,
    err:     pld_err,
    dat:     pld_dat,
    seg_len: meta_len // Payload length of the current segment
  };

endmodule

//--- rtl/tcp_rx_ack.sv
`timescale 1ns/1ns
`include "tcp_settings.svh"

module tcp_rx_ack #(
  parameter int TIMEOUT           = `TCP_ACK_TIMEOUT,
  parameter int FORCE_ACK_PACKETS = `TCP_FORCE_ACK_PACKETS
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               init,
  input  tcp_pkg::tcp_tcb_t  tcb,
  input  tcp_pkg::tcp_meta_t meta,
  input  tcp_pkg::tcp_strm_t pld,
  input  logic               accept,
  output logic [31:0]        loc_ack,
  output logic               send_ack,
  input  logic               ack_sent
);

  localparam int TMR_W = $clog2(TIMEOUT + 1);
  localparam int CNT_W = $clog2(FORCE_ACK_PACKETS + 1);

  logic             pending;   // Accepted segment still in flight
  logic [15:0]      len_q;
  logic [15:0]      len_cur;
  logic             seg_end;
  logic             good_end;
  logic [CNT_W-1:0] unack_cnt;
  logic [TMR_W-1:0] tmr;
  logic             raise;

  // A one-byte payload ends in the same cycle as its accept
  assign len_cur  = accept ? meta.pld_len : len_q;
  assign seg_end  = pld.val && pld.eof && (pending || accept);
  assign good_end = seg_end && !pld.err;

  // Only one request outstanding at a time
  assign raise = !send_ack &&
                 ((unack_cnt == CNT_W'(FORCE_ACK_PACKETS)) || (tmr == TMR_W'(TIMEOUT)));

  always_ff @(posedge clk) begin
    if (accept) begin
      len_q <= meta.pld_len;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending   <= 1'b0;
      loc_ack   <= '0;
      unack_cnt <= '0;
      tmr       <= '0;
      send_ack  <= 1'b0;
    end else begin
      if (seg_end) begin
        pending <= 1'b0;
      end else if (accept) begin
        pending <= 1'b1;
      end else if (meta.val) begin
        pending <= 1'b0; // Previous segment never finished
      end

      if (init) begin
        loc_ack <= tcb.rem_seq;
      end else if (good_end) begin
        loc_ack <= loc_ack + {16'd0, len_cur};
      end

      if (init) begin
        unack_cnt <= '0;
        tmr       <= '0;
      end else if (raise) begin
        unack_cnt <= good_end ? CNT_W'(1) : '0;
        tmr       <= '0;
      end else begin
        if (good_end && unack_cnt != CNT_W'(FORCE_ACK_PACKETS)) begin
          unack_cnt <= unack_cnt + CNT_W'(1);
        end
        if (unack_cnt != '0 && tmr != TMR_W'(TIMEOUT)) begin
          tmr <= tmr + TMR_W'(1); // Runs from first unacked segment
        end
      end

      if (raise) begin
        send_ack <= 1'b1;
      end else if (ack_sent) begin
        send_ack <= 1'b0;
      end
    end
  end

endmodule

//--- rtl/tcp_rx_ctl.sv
`timescale 1ns/1ns

module tcp_rx_ctl (
  input  logic                 clk,
  input  logic                 rst,
  input  tcp_pkg::tcp_meta_t   meta,
  input  tcp_pkg::tcp_strm_t   pld,
  input  logic [31:0]          loc_ack,
  input  tcp_pkg::tcp_status_t status,
  input  tcp_pkg::tcp_tcb_t    tcb,
  output logic                 accept,
  output tcp_pkg::tcp_data_t   data
);

  logic       port_ok;
  logic       seq_ok;
  logic       hit;
  logic       receiving; // Current segment passed the filter

  logic       val_q;
  logic       eof_q;
  logic       err_q;
  logic [7:0] dat_q;

  // Remote sends from rem_port to our loc_port
  assign port_ok = (meta.hdr.src_port == tcb.rem_port) &&
                   (meta.hdr.dst_port == tcb.loc_port);

  assign seq_ok = (meta.hdr.seq_num == loc_ack); // In-order only

  assign hit = meta.val && port_ok && seq_ok &&
               (status == tcp_pkg::tcp_connected) && (meta.pld_len != 16'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      accept    <= 1'b0;
      receiving <= 1'b0;
      val_q     <= 1'b0;
    end else begin
      accept <= hit;
      val_q  <= pld.val;
      // Every new header decides afresh
      if (meta.val) begin
        receiving <= hit;
      end else if (val_q && eof_q) begin
        receiving <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    dat_q <= pld.dat;
    eof_q <= pld.eof;
    err_q <= pld.err;
  end

  // Rejected payload never reaches the user
  assign data.val = receiving && val_q;
  assign data.eof = receiving && eof_q;
  assign data.err = receiving && err_q;
  assign data.dat = dat_q;

endmodule

//--- rtl/tcp_rx.sv
`timescale 1ns/1ns

module tcp_rx (
  input  logic                 clk,
  input  logic                 rst,
  input  tcp_pkg::tcp_strm_t   rx,
  input  tcp_pkg::tcp_tcb_t    tcb,
  input  logic                 init,
  input  tcp_pkg::tcp_status_t status,
  output tcp_pkg::tcp_data_t   data,
  output logic [31:0]          loc_ack,
  output logic                 send_ack,
  input  logic                 ack_sent
);

  tcp_pkg::tcp_meta_t meta;
  tcp_pkg::tcp_strm_t pld;
  logic               accept;

  tcp_rx_hdr_parse u_hdr_parse (
    .clk  (clk),
    .rst  (rst),
    .rx   (rx),
    .meta (meta),
    .pld  (pld)
  );

  tcp_rx_ctl u_ctl (
    .clk     (clk),
    .rst     (rst),
    .meta    (meta),
    .pld     (pld),
    .loc_ack (loc_ack),
    .status  (status),
    .tcb     (tcb),
    .accept  (accept),
    .data    (data)
  );

  tcp_rx_ack u_ack (
    .clk      (clk),
    .rst      (rst),
    .init     (init),
    .tcb      (tcb),
    .meta     (meta),
    .pld      (pld),
    .accept   (accept),
    .loc_ack  (loc_ack),
    .send_ack (send_ack),
    .ack_sent (ack_sent)
  );

endmodule

//--- sim/tcp_rx_props.sv
`timescale 1ns/1ns

module tcp_rx_props (
  input logic               clk,
  input logic               rst,
  input logic               init,
  input tcp_pkg::tcp_strm_t pld,
  input tcp_pkg::tcp_data_t data,
  input logic [31:0]        loc_ack,
  input logic               send_ack,
  input logic               ack_sent
);

  // Request stays up until the TX side answers
  ack_hold: assert property (@(posedge clk) disable iff (rst)
    send_ack && !ack_sent |=> send_ack)
    else $error("send_ack dropped before ack_sent");

  rst_quiet: assert property (@(posedge clk) rst |=> !data.val && !send_ack)
    else $error("user stream or ACK request active after reset");

  // loc_ack moves only at a segment end or on init
  ack_stable: assert property (@(posedge clk) disable iff (rst)
    (loc_ack != $past(loc_ack)) |-> ($past(init) || ($past(pld.val) && $past(pld.eof))))
    else $error("loc_ack changed without eof or init");

endmodule

bind tcp_rx tcp_rx_props i_props (
  .clk      (clk),
  .rst      (rst),
  .init     (init),
  .pld      (pld),
  .data     (data),
  .loc_ack  (loc_ack),
  .send_ack (send_ack),
  .ack_sent (ack_sent)
);

//--- sim/tcp_rx_tb.sv
`timescale 1ns/1ns

module tcp_rx_tb;

  logic                 clk;
  logic                 rst;
  tcp_pkg::tcp_strm_t   rx;
  tcp_pkg::tcp_tcb_t    tcb;
  logic                 init;
  tcp_pkg::tcp_status_t status;
  tcp_pkg::tcp_data_t   data;
  logic [31:0]          loc_ack;
  logic                 send_ack;
  logic                 ack_sent;

  logic [9:0]       rcv_q[$];  // {err, eof, dat} of each user byte
  logic [7:0]       byte_q[$]; // Payload or expected bytes of the current command
  logic [31:0]      fld[6];
  logic [8*16-1:0]  cmd;
  logic [8*24-1:0]  test_name;
  logic [8*128-1:0] line;
  int               fd;
  int               code;
  int               errors;
  int               test_errs;
  int               tests;
  int               failed_tests;
  bit               in_test;
  bit               aborted;

  tcp_rx i_tcp_rx (
    .clk      (clk),
    .rst      (rst),
    .rx       (rx),
    .tcb      (tcb),
    .init     (init),
    .status   (status),
    .data     (data),
    .loc_ack  (loc_ack),
    .send_ack (send_ack),
    .ack_sent (ack_sent)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // User bytes are stable at the falling edge
  always @(negedge clk) begin
    if (!rst && data.val) begin
      rcv_q.push_back({data.err, data.eof, data.dat});
    end
  end

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic read_hex(output logic [31:0] v);
    int c;
    c = $fscanf(fd, "%h", v);
    if (c != 1) begin
      $display("Trace file is malformed: a hex field is missing");
      errors = errors + 1;
      aborted = 1'b1;
      v = '0;
    end
  endtask

  task automatic read_fields(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      read_hex(fld[i]);
    end
  endtask

  task automatic read_bytes(input logic [31:0] n);
    int         i;
    logic [31:0] v;
    byte_q.delete();
    for (i = 0; i < int'(n) && i < 64 && !aborted; i++) begin
      read_hex(v);
      byte_q.push_back(v[7:0]);
    end
  endtask

  task automatic setup_connection(input logic [15:0] lp, input logic [15:0] rp,
                                  input logic [31:0] seq, input logic st);
    tcb.loc_port = lp;
    tcb.rem_port = rp;
    tcb.rem_seq  = seq;
    status = st ? tcp_pkg::tcp_connected : tcp_pkg::tcp_closed;
    step_cycle();
    init = 1'b1;
    step_cycle();
    init = 1'b0;
  endtask

  // Header, NOP options, then the payload from byte_q
  task automatic send_segment(input logic [15:0] src, input logic [15:0] dst,
                              input logic [31:0] seq, input logic [3:0] off,
                              input logic err_last);
    tcp_pkg::tcp_hdr_t hdr;
    logic [7:0]        bytes_out[$];
    int                hlen;
    int                i;
    hdr = '0;
    hdr.src_port   = src;
    hdr.dst_port   = dst;
    hdr.seq_num    = seq;
    hdr.data_off   = off;
    hdr.flags.ack  = 1'b1;
    hdr.flags.psh  = 1'b1;
    hdr.win        = 16'hffff;
    hlen = off * 4;
    for (i = 0; i < 20; i++) begin
      bytes_out.push_back(hdr[159 - 8*i -: 8]);
    end
    for (i = 20; i < hlen; i++) begin
      bytes_out.push_back(8'h01);
    end
    for (i = 0; i < byte_q.size(); i++) begin
      bytes_out.push_back(byte_q[i]);
    end
    for (i = 0; i < bytes_out.size(); i++) begin
      rx.val     = 1'b1;
      rx.sof     = (i == 0);
      rx.eof     = (i == bytes_out.size() - 1);
      rx.err     = err_last && rx.eof;
      rx.dat     = bytes_out[i];
      rx.seg_len = 16'(bytes_out.size());
      step_cycle();
    end
    rx = '0;
    repeat (4) step_cycle(); // Idle gap between segments
  endtask

  task automatic verify_user_bytes(input logic err_last);
    int n;
    int i;
    int waited;
    n = byte_q.size();
    waited = 0;
    while (rcv_q.size() < n && waited < 20) begin
      step_cycle();
      waited++;
    end
    if (rcv_q.size() < n) begin
      $display("Timeout at %0t ns: only %0d of %0d user bytes arrived", $time,
               rcv_q.size(), n);
      errors = errors + 1;
    end
    for (i = 0; i < n && i < rcv_q.size(); i++) begin
      compare_value("data.dat", 32'(rcv_q[i][7:0]), 32'(byte_q[i]));
      compare_value("data.eof", 32'(rcv_q[i][8]), 32'(i == n - 1));
      compare_value("data.err", 32'(rcv_q[i][9]), 32'(err_last && (i == n - 1)));
    end
    if (rcv_q.size() > n) begin
      $display("At %0t ns the user stream showed %0d bytes where %0d were expected",
               $time, rcv_q.size(), n);
      errors = errors + 1;
    end
    rcv_q.delete();
  endtask

  task automatic serve_ack_request(input int limit, input logic [31:0] exp_ack);
    int waited;
    waited = 0;
    while (!send_ack && waited < limit) begin
      step_cycle();
      waited++;
    end
    if (!send_ack) begin
      $display("Timeout at %0t ns: no ACK request within %0d cycles", $time, limit);
      errors = errors + 1;
    end else begin
      compare_value("loc_ack", loc_ack, exp_ack);
      repeat (2) begin
        step_cycle();
        compare_value("send_ack", 32'(send_ack), 32'd1); // Held while TX is busy
      end
      ack_sent = 1'b1;
      step_cycle();
      ack_sent = 1'b0;
      compare_value("send_ack", 32'(send_ack), 32'd0);
    end
  endtask

  task automatic close_test();
    if (in_test) begin
      tests++;
      if (errors == test_errs) begin
        $display("Test %0s: passed", test_name);
      end else begin
        $display("Test %0s: failed with %0d errors", test_name, errors - test_errs);
        failed_tests++;
      end
    end
  endtask

  initial begin
    rst      = 1'b1;
    rx       = '0;
    tcb      = '0;
    init     = 1'b0;
    status   = tcp_pkg::tcp_closed;
    ack_sent = 1'b0;
    errors   = 0;
    tests    = 0;
    failed_tests = 0;
    in_test  = 1'b0;
    aborted  = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    fd = $fopen("sim/tcp_rx_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file sim/tcp_rx_trace.txt");
      errors = errors + 1;
    end else begin
      while (!aborted) begin
        code = $fscanf(fd, "%s", cmd);
        if (code != 1) break;
        if (cmd == "#") begin
          code = $fgets(line, fd);
        end else if (cmd == "test") begin
          close_test();
          code = $fscanf(fd, "%s", test_name);
          in_test   = 1'b1;
          test_errs = errors;
        end else if (cmd == "tcb") begin
          read_fields(4);
          setup_connection(fld[0][15:0], fld[1][15:0], fld[2], fld[3][0]);
        end else if (cmd == "seg") begin
          read_fields(6);
          read_bytes(fld[5]);
          send_segment(fld[0][15:0], fld[1][15:0], fld[2], fld[3][3:0], fld[4][0]);
        end else if (cmd == "data") begin
          read_fields(2);
          read_bytes(fld[1]);
          verify_user_bytes(fld[0][0]);
        end else if (cmd == "ack") begin
          read_fields(1);
          compare_value("loc_ack", loc_ack, fld[0]);
        end else if (cmd == "req") begin
          read_fields(2);
          serve_ack_request(int'(fld[0]), fld[1]);
        end else begin
          $display("Unknown command %0s in the trace file", cmd);
          errors = errors + 1;
          aborted = 1'b1;
        end
      end
      $fclose(fd);
    end
    close_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0 && tests > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- sim/tcp_rx_trace.txt
# Fields hex: test <name> | tcb <loc_port> <rem_port> <rem_seq> <status> | ack <loc_ack>
# seg <src> <dst> <seq> <data_off> <err> <n> <bytes> | data <err> <n> <bytes> | req <cycles> <loc_ack>
test in_order
tcb 1f90 c350 00001000 1
seg c350 1f90 00001000 5 0 4 de ad be ef
data 0 4 de ad be ef
ack 00001004
test timeout_ack
req 18 00001004
test options
seg c350 1f90 00001004 6 0 3 11 22 33
data 0 3 11 22 33
ack 00001007
req 18 00001007
test reject
seg c350 1f91 00001007 5 0 2 55 66
data 0 0
seg c350 1f90 00001000 5 0 2 77 88
data 0 0
ack 00001007
test errored
seg c350 1f90 00001007 5 1 3 a1 a2 a3
data 1 3 a1 a2 a3
ack 00001007
test forced_ack
seg c350 1f90 00001007 5 0 2 01 02
data 0 2 01 02
seg c350 1f90 00001009 5 0 2 03 04
data 0 2 03 04
seg c350 1f90 0000100b 5 0 2 05 06
data 0 2 05 06
seg c350 1f90 0000100d 5 0 2 07 08
data 0 2 07 08
req 08 0000100f
req 04 0000100f
ack 0000100f

//--- sim.f
+incdir+rtl
rtl/tcp_pkg.sv
rtl/tcp_rx_hdr_parse.sv
rtl/tcp_rx_ack.sv
rtl/tcp_rx_ctl.sv
rtl/tcp_rx.sv
sim/tcp_rx_props.sv
sim/tcp_rx_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tcp_rx_tb -Mdir obj_dir -o tcp_rx_sim -f sim.f

./obj_dir/tcp_rx_sim | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
